// ==== design/csr_consts.svh ====
// Register width, CSR addresses, mstatus field positions,
// interrupt and exception cause codes for the machine-mode CSR unit

`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Register width of the RV32 core
`define CSR_XLEN 32

// Machine-mode CSR addresses
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MISA     12'h301
`define CSR_ADDR_MIE      12'h304
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MTVAL    12'h343
`define CSR_ADDR_MIP      12'h344

// mstatus fields
`define CSR_BIT_MIE  3
`define CSR_BIT_MPIE 7
// Low bit of the 2-bit MPP field
`define CSR_BIT_MPP  11

// Interrupt bit positions in mie/mip, same values as the cause codes
`define CSR_IRQ_MSI 3
`define CSR_IRQ_MTI 7
`define CSR_IRQ_MEI 11

// Exception cause codes
`define CSR_EXC_ILLEGAL 2
`define CSR_EXC_ECALL_U 8
`define CSR_EXC_ECALL_M 11

// Width of the cause code field kept by the trap logic
`define CSR_CODE_W 5

// misa: MXL=1 (RV32), I and U extensions
`define CSR_MISA_VALUE 32'h4010_0100

`endif

// ==== design/csr_pkg.sv ====
// Shared types of the CSR unit: register word, CSR address,
// privilege level and the enabled-pending interrupt vector

`default_nettype none

package csr_pkg;

`include "csr_consts.svh"

  // One CSR word
  typedef logic [`CSR_XLEN-1:0] csr_data_t;

  // 12-bit CSR address space
  typedef logic [11:0] csr_addr_t;

  // Only user and machine exist, supervisor encodings are unused
  typedef enum logic [1:0] {
    PRIV_USER    = 2'b00,
    PRIV_MACHINE = 2'b11
  } priv_mode_t;

  // Interrupts that are both pending and enabled
  typedef struct packed {
    logic mei;
    logic mti;
    logic msi;
  } irq_vec_t;

endpackage

`default_nettype wire

// ==== design/csr_status.sv ====
// mstatus fields (MIE, MPIE, MPP) and the current privilege level

`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_status import csr_pkg::*; (
  input  wire        clock,
  input  wire        reset,
  input  wire        wr_en,
  input  csr_addr_t  addr,
  input  csr_data_t  wr_data,
  input  wire        trap,
  input  wire        mret,
  output csr_data_t  mstatus,
  output priv_mode_t priv
);

  logic       mie_bit;
  logic       mpie;
  priv_mode_t mpp;
  logic [1:0] wr_mpp;
  logic       wr_mstatus;

  assign wr_mpp     = wr_data[`CSR_BIT_MPP +: 2];
  assign wr_mstatus = wr_en && !trap && (addr == `CSR_ADDR_MSTATUS);

  // Trap entry wins over mret, mret over a software write
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mie_bit <= 1'b0;
      mpie    <= 1'b0;
      mpp     <= PRIV_USER;
      priv    <= PRIV_MACHINE;
    end else if (trap) begin
      mie_bit <= 1'b0;
      mpie    <= mie_bit;
      mpp     <= priv;
      priv    <= PRIV_MACHINE;
    end else if (mret) begin
      mie_bit <= mpie;
      mpie    <= 1'b1;
      mpp     <= PRIV_USER;
      priv    <= mpp;
    end else if (wr_mstatus) begin
      mie_bit <= wr_data[`CSR_BIT_MIE];
      mpie    <= wr_data[`CSR_BIT_MPIE];
      // MPP is WARL, supervisor encodings keep the old value
      if (wr_mpp == PRIV_USER || wr_mpp == PRIV_MACHINE) begin
        mpp <= priv_mode_t'(wr_mpp);
      end
    end
  end

  always_comb begin
    mstatus                     = '0;
    mstatus[`CSR_BIT_MIE]       = mie_bit;
    mstatus[`CSR_BIT_MPIE]      = mpie;
    mstatus[`CSR_BIT_MPP +: 2]  = mpp;
  end

  // Neither trap entry nor mret may leave a supervisor level behind
  a_priv_legal: assert property (
    @(posedge clock) disable iff (reset)
    priv inside {PRIV_USER, PRIV_MACHINE}
  ) else $error("csr_status: unsupported privilege level %b", priv);

endmodule

`default_nettype wire

// ==== design/csr_interrupts.sv ====
// mie enable bits, mip built from the live interrupt sources
// and the enabled-pending interrupt vector

`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_interrupts import csr_pkg::*; (
  input  wire         clock,
  input  wire         reset,
  input  wire         wr_en,
  input  csr_addr_t   addr,
  input  csr_data_t   wr_data,
  input  wire         trap,
  input  csr_data_t   mstatus,
  input  priv_mode_t  priv,
  input  wire         msip,
  input  wire         external_interrupt,
  input  wire  [63:0] mtime,
  input  wire  [63:0] mtimecmp,
  output csr_data_t   mie_reg,
  output csr_data_t   mip_reg,
  output irq_vec_t    irq
);

  logic msie;
  logic mtie;
  logic meie;
  logic global_en;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      msie <= 1'b0;
      mtie <= 1'b0;
      meie <= 1'b0;
    end else if (wr_en && !trap && (addr == `CSR_ADDR_MIE)) begin
      msie <= wr_data[`CSR_IRQ_MSI];
      mtie <= wr_data[`CSR_IRQ_MTI];
      meie <= wr_data[`CSR_IRQ_MEI];
    end
  end

  always_comb begin
    mie_reg                 = '0;
    mie_reg[`CSR_IRQ_MSI]   = msie;
    mie_reg[`CSR_IRQ_MTI]   = mtie;
    mie_reg[`CSR_IRQ_MEI]   = meie;
    // Read-only view of the sources
    mip_reg                 = '0;
    mip_reg[`CSR_IRQ_MSI]   = msip;
    mip_reg[`CSR_IRQ_MTI]   = (mtime >= mtimecmp);
    mip_reg[`CSR_IRQ_MEI]   = external_interrupt;
  end

  // User mode always takes machine interrupts
  assign global_en = (priv == PRIV_USER) || mstatus[`CSR_BIT_MIE];

  assign irq.mei = mie_reg[`CSR_IRQ_MEI] & mip_reg[`CSR_IRQ_MEI] & global_en;
  assign irq.mti = mie_reg[`CSR_IRQ_MTI] & mip_reg[`CSR_IRQ_MTI] & global_en;
  assign irq.msi = mie_reg[`CSR_IRQ_MSI] & mip_reg[`CSR_IRQ_MSI] & global_en;

endmodule

`default_nettype wire

// ==== design/csr_trap_ctrl.sv ====
// Trap priority, cause value and trap target address

`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_trap_ctrl import csr_pkg::*; (
  input  irq_vec_t   irq,
  input  wire        illegal_instruction,
  input  wire        ecall,
  input  priv_mode_t priv,
  input  csr_data_t  mtvec,
  output logic       trap,
  output csr_data_t  cause,
  output csr_data_t  trap_addr,
  output logic       take_exception_illegal
);

  logic                   is_irq;
  logic [`CSR_CODE_W-1:0] code;
  logic [`CSR_CODE_W-1:0] ecall_code;
  csr_data_t              base;
  csr_data_t              offset;

  assign is_irq = irq.mei | irq.mti | irq.msi;

  // ecall cause depends on the level that issued it
  assign ecall_code = (priv == PRIV_USER) ? `CSR_CODE_W'(`CSR_EXC_ECALL_U)
                                          : `CSR_CODE_W'(`CSR_EXC_ECALL_M);

  // Interrupts beat exceptions, MEI > MTI > MSI > illegal > ecall
  always_comb begin
    code = '0;
    if (irq.mei) begin
      code = `CSR_CODE_W'(`CSR_IRQ_MEI);
    end else if (irq.mti) begin
      code = `CSR_CODE_W'(`CSR_IRQ_MTI);
    end else if (irq.msi) begin
      code = `CSR_CODE_W'(`CSR_IRQ_MSI);
    end else if (illegal_instruction) begin
      code = `CSR_CODE_W'(`CSR_EXC_ILLEGAL);
    end else if (ecall) begin
      code = ecall_code;
    end
  end

  assign trap                   = is_irq | illegal_instruction | ecall;
  assign take_exception_illegal = !is_irq && illegal_instruction;

  // Top bit flags an interrupt
  assign cause = {is_irq, {(`CSR_XLEN-1-`CSR_CODE_W){1'b0}}, code};

  assign base = {mtvec[`CSR_XLEN-1:2], 2'b00};

  // Vectored mode only moves interrupts, exceptions go to the base
  always_comb begin
    if (mtvec[0] && is_irq) begin
      offset = {{(`CSR_XLEN-2-`CSR_CODE_W){1'b0}}, code, 2'b00};
    end else begin
      offset = '0;
    end
  end

  assign trap_addr = base + offset;

endmodule

`default_nettype wire

// ==== design/csr_file.sv ====
// mtvec, mscratch, mepc, mcause and mtval registers
// plus the CSR read multiplexer

`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_file import csr_pkg::*; (
  input  wire       clock,
  input  wire       reset,
  input  wire       wr_en,
  input  csr_addr_t addr,
  input  csr_data_t wr_data,
  input  wire       trap,
  input  csr_data_t cause,
  input  wire       take_exception_illegal,
  input  csr_data_t pc,
  input  csr_data_t instruction,
  input  wire       mret,
  input  csr_data_t mstatus,
  input  csr_data_t mie_reg,
  input  csr_data_t mip_reg,
  output csr_data_t mtvec,
  output csr_data_t mepc,
  output csr_data_t rd_data
);

  csr_data_t mscratch;
  csr_data_t mcause;
  csr_data_t mtval;
  logic      wr_ok;
  logic      mcause_legal;

  // mcause is WLRL, only codes this core can raise
  function automatic logic legal_cause(input csr_data_t value);
    logic [`CSR_XLEN-2:0] code;
    code = value[`CSR_XLEN-2:0];
    if (value[`CSR_XLEN-1]) begin
      return (code == `CSR_IRQ_MSI) || (code == `CSR_IRQ_MTI) || (code == `CSR_IRQ_MEI);
    end
    return (code == `CSR_EXC_ILLEGAL) || (code == `CSR_EXC_ECALL_U) ||
           (code == `CSR_EXC_ECALL_M);
  endfunction

  assign wr_ok        = wr_en && !trap;
  assign mcause_legal = legal_cause(wr_data);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else if (trap) begin
      mepc   <= {pc[`CSR_XLEN-1:2], 2'b00};
      mcause <= cause;
      if (take_exception_illegal) begin
        mtval <= instruction;
      end
    end else if (wr_ok) begin
      case (addr)
        // Bit 1 of mtvec is reserved
        `CSR_ADDR_MTVEC:    mtvec    <= {wr_data[`CSR_XLEN-1:2], 1'b0, wr_data[0]};
        `CSR_ADDR_MSCRATCH: mscratch <= wr_data;
        `CSR_ADDR_MEPC:     mepc     <= {wr_data[`CSR_XLEN-1:2], 2'b00};
        `CSR_ADDR_MCAUSE: begin
          if (mcause_legal) begin
            mcause <= wr_data;
          end
        end
        `CSR_ADDR_MTVAL:    mtval    <= wr_data;
        default: ;
      endcase
    end
  end

  // Unknown addresses read zero
  always_comb begin
    case (addr)
      `CSR_ADDR_MSTATUS:  rd_data = mstatus;
      `CSR_ADDR_MISA:     rd_data = `CSR_MISA_VALUE;
      `CSR_ADDR_MIE:      rd_data = mie_reg;
      `CSR_ADDR_MTVEC:    rd_data = mtvec;
      `CSR_ADDR_MSCRATCH: rd_data = mscratch;
      `CSR_ADDR_MEPC:     rd_data = mepc;
      `CSR_ADDR_MCAUSE:   rd_data = mcause;
      `CSR_ADDR_MTVAL:    rd_data = mtval;
      `CSR_ADDR_MIP:      rd_data = mip_reg;
      default:            rd_data = '0;
    endcase
  end

  // Core never issues a CSR write together with mret
  a_no_wr_with_mret: assert property (
    @(posedge clock) disable iff (reset) !(wr_en && mret)
  ) else $error("csr_file: wr_en and mret high together");

  // mret is not expected while a trap is being taken
  a_no_mret_with_trap: assert property (
    @(posedge clock) disable iff (reset) !(mret && trap)
  ) else $error("csr_file: mret during trap");

  // Holds across trap entry and software writes alike
  a_mepc_aligned: assert property (
    @(posedge clock) disable iff (reset) mepc[1:0] == 2'b00
  ) else $error("csr_file: mepc misaligned %h", mepc);

endmodule

`default_nettype wire

// ==== design/csr_unit.sv ====
// Top of the machine-mode CSR unit, connects status, interrupts,
// trap control and the register file

`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_unit import csr_pkg::*; (
  input  wire         clock,
  input  wire         reset,
  input  wire         wr_en,
  input  csr_addr_t   addr,
  input  csr_data_t   wr_data,
  input  csr_data_t   pc,
  input  csr_data_t   instruction,
  input  wire  [63:0] mtime,
  input  wire  [63:0] mtimecmp,
  input  wire         msip,
  input  wire         external_interrupt,
  input  wire         illegal_instruction,
  input  wire         ecall,
  input  wire         mret,
  output csr_data_t   rd_data,
  output csr_data_t   mepc,
  output logic        trap,
  output csr_data_t   trap_addr,
  output priv_mode_t  priv
);

  csr_data_t mstatus;
  csr_data_t mie_reg;
  csr_data_t mip_reg;
  csr_data_t mtvec;
  csr_data_t cause;
  irq_vec_t  irq;
  logic      take_exception_illegal;

  csr_status csr_status_i (
    .clock   (clock),
    .reset   (reset),
    .wr_en   (wr_en),
    .addr    (addr),
    .wr_data (wr_data),
    .trap    (trap),
    .mret    (mret),
    .mstatus (mstatus),
    .priv    (priv)
  );

  csr_interrupts csr_interrupts_i (
    .clock              (clock),
    .reset              (reset),
    .wr_en              (wr_en),
    .addr               (addr),
    .wr_data            (wr_data),
    .trap               (trap),
    .mstatus            (mstatus),
    .priv               (priv),
    .msip               (msip),
    .external_interrupt (external_interrupt),
    .mtime              (mtime),
    .mtimecmp           (mtimecmp),
    .mie_reg            (mie_reg),
    .mip_reg            (mip_reg),
    .irq                (irq)
  );

  // Trap decision is purely combinational
  csr_trap_ctrl csr_trap_ctrl_i (
    .irq                    (irq),
    .illegal_instruction    (illegal_instruction),
    .ecall                  (ecall),
    .priv                   (priv),
    .mtvec                  (mtvec),
    .trap                   (trap),
    .cause                  (cause),
    .trap_addr              (trap_addr),
    .take_exception_illegal (take_exception_illegal)
  );

  csr_file csr_file_i (
    .clock                  (clock),
    .reset                  (reset),
    .wr_en                  (wr_en),
    .addr                   (addr),
    .wr_data                (wr_data),
    .trap                   (trap),
    .cause                  (cause),
    .take_exception_illegal (take_exception_illegal),
    .pc                     (pc),
    .instruction            (instruction),
    .mret                   (mret),
    .mstatus                (mstatus),
    .mie_reg                (mie_reg),
    .mip_reg                (mip_reg),
    .mtvec                  (mtvec),
    .mepc                   (mepc),
    .rd_data                (rd_data)
  );

endmodule

`default_nettype wire

// ==== testbench/csr_unit_tb.sv ====
// Testbench for the CSR unit with clock and reset, LFSR write data,
// stimulus table with expected results and the check task

`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_unit_tb import csr_pkg::*; ();

  typedef struct packed {
    logic illegal, ecall, mret, msip, ext, timer;
  } events_t;

  typedef struct {
    string      name;
    csr_addr_t  addr;
    logic       wr_en;
    csr_data_t  wr_data, pc, instruction;
    events_t    ev;
    csr_data_t  exp_rd, exp_addr;
    logic       exp_trap;
    priv_mode_t exp_priv;
  } row_t;

  logic        clock, reset, wr_en, msip, external_interrupt;
  logic        illegal_instruction, ecall, mret, trap;
  csr_addr_t   addr;
  csr_data_t   wr_data, pc, instruction, rd_data, mepc, trap_addr;
  logic [63:0] mtime, mtimecmp;
  priv_mode_t  priv;

  logic [31:0] lfsr = 32'h8e84_024d;
  row_t        rows[$];
  row_t        nxt;

  csr_unit csr_unit_i (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic csr_data_t random_word();
    csr_data_t w;
    logic      fb;
    w = '0;
    for (int i = 0; i < `CSR_XLEN; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      w    = {w[`CSR_XLEN-2:0], fb};
    end
    return w;
  endfunction

  function automatic csr_data_t status_word(input logic mie, input logic mpie,
                                            input logic [1:0] mpp);
    csr_data_t w;
    w                    = '0;
    w[`CSR_BIT_MIE]      = mie;
    w[`CSR_BIT_MPIE]     = mpie;
    w[`CSR_BIT_MPP +: 2] = mpp;
    return w;
  endfunction

  task automatic check_value(input string name, input csr_data_t expected,
                             input csr_data_t actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_row(input string name, input csr_addr_t a, input logic we,
                         input csr_data_t wd, input csr_data_t exp_rd, input logic exp_trap,
                         input csr_data_t exp_addr, input priv_mode_t exp_priv);
    nxt.name     = name;
    nxt.addr     = a;
    nxt.wr_en    = we;
    nxt.wr_data  = wd;
    nxt.exp_rd   = exp_rd;
    nxt.exp_trap = exp_trap;
    nxt.exp_addr = exp_addr;
    nxt.exp_priv = exp_priv;
    rows.push_back(nxt);
    // Events last for one row only
    nxt.ev = '0;
  endtask

  task automatic build_table();
    csr_data_t s_d, t_d, e_d, v_d, pc1, ins1, misa, tv, base_t, base_v;
    s_d    = random_word();
    t_d    = random_word();
    e_d    = random_word();
    v_d    = random_word();
    pc1    = random_word();
    ins1   = random_word();
    misa   = (32'd1 << 30) | (32'd1 << 20) | (32'd1 << 8);
    tv     = {t_d[31:2], 1'b0, t_d[0]};
    base_t = {t_d[31:2], 2'b00};
    base_v = {v_d[31:2], 2'b00};
    nxt.ev          = '0;
    nxt.pc          = '0;
    nxt.instruction = '0;
    // Plain register access
    add_row("mscratch write", `CSR_ADDR_MSCRATCH, 1, s_d, 0, 0, 0, PRIV_MACHINE);
    add_row("mtvec write", `CSR_ADDR_MTVEC, 1, t_d, 0, 0, 0, PRIV_MACHINE);
    add_row("mepc write", `CSR_ADDR_MEPC, 1, e_d, 0, 0, base_t, PRIV_MACHINE);
    add_row("mscratch read", `CSR_ADDR_MSCRATCH, 0, 0, s_d, 0, base_t, PRIV_MACHINE);
    add_row("mtvec read", `CSR_ADDR_MTVEC, 0, 0, tv, 0, base_t, PRIV_MACHINE);
    add_row("mepc read", `CSR_ADDR_MEPC, 0, 0, {e_d[31:2], 2'b00}, 0, base_t, PRIV_MACHINE);
    add_row("misa read", `CSR_ADDR_MISA, 0, 0, misa, 0, base_t, PRIV_MACHINE);
    add_row("unknown read", 12'h7c0, 0, 0, 0, 0, base_t, PRIV_MACHINE);
    // WARL and WLRL fields
    add_row("mcause legal", `CSR_ADDR_MCAUSE, 1, 11, 0, 0, base_t, PRIV_MACHINE);
    add_row("mcause illegal", `CSR_ADDR_MCAUSE, 1, 5, 11, 0, base_t, PRIV_MACHINE);
    add_row("mcause kept", `CSR_ADDR_MCAUSE, 0, 0, 11, 0, base_t, PRIV_MACHINE);
    add_row("mpp machine", `CSR_ADDR_MSTATUS, 1, status_word(0, 0, 2'b11), 0, 0, base_t,
            PRIV_MACHINE);
    add_row("mpp reserved", `CSR_ADDR_MSTATUS, 1, status_word(0, 1, 2'b10),
            status_word(0, 0, 2'b11), 0, base_t, PRIV_MACHINE);
    nxt.ev.illegal  = 1'b1;
    nxt.pc          = pc1;
    nxt.instruction = ins1;
    add_row("illegal instruction", `CSR_ADDR_MSTATUS, 0, 0, status_word(0, 1, 2'b11), 1,
            base_t, PRIV_MACHINE);
    add_row("mcause after illegal", `CSR_ADDR_MCAUSE, 0, 0, 2, 0, base_t, PRIV_MACHINE);
    add_row("mtval after illegal", `CSR_ADDR_MTVAL, 0, 0, ins1, 0, base_t, PRIV_MACHINE);
    add_row("mepc after illegal", `CSR_ADDR_MEPC, 0, 0, {pc1[31:2], 2'b00}, 0, base_t,
            PRIV_MACHINE);
    // mret to user, then ecall back
    add_row("mpp user", `CSR_ADDR_MSTATUS, 1, status_word(0, 1, 2'b00),
            status_word(0, 0, 2'b11), 0, base_t, PRIV_MACHINE);
    nxt.ev.mret = 1'b1;
    add_row("mret", `CSR_ADDR_MSTATUS, 0, 0, status_word(0, 1, 2'b00), 0, base_t,
            PRIV_MACHINE);
    nxt.ev.ecall = 1'b1;
    add_row("ecall from user", `CSR_ADDR_MSTATUS, 0, 0, status_word(1, 1, 2'b00), 1,
            base_t, PRIV_USER);
    add_row("mcause after ecall", `CSR_ADDR_MCAUSE, 0, 0, 8, 0, base_t, PRIV_MACHINE);
    add_row("mie on, mpp was user", `CSR_ADDR_MSTATUS, 1, status_word(1, 0, 2'b11),
            status_word(0, 1, 2'b00), 0, base_t, PRIV_MACHINE);
    // Interrupts, vectored mode
    add_row("mtvec vectored", `CSR_ADDR_MTVEC, 1, base_v | 1, tv, 0, base_t, PRIV_MACHINE);
    add_row("mie enable", `CSR_ADDR_MIE, 1,
            (1 << `CSR_IRQ_MSI) | (1 << `CSR_IRQ_MTI) | (1 << `CSR_IRQ_MEI), 0, 0, base_v,
            PRIV_MACHINE);
    nxt.ev.timer = 1'b1;
    add_row("timer interrupt", `CSR_ADDR_MCAUSE, 0, 0, 8, 1, base_v + 28, PRIV_MACHINE);
    add_row("mie on again", `CSR_ADDR_MSTATUS, 1, status_word(1, 0, 2'b11),
            status_word(0, 1, 2'b11), 0, base_v, PRIV_MACHINE);
    nxt.ev.msip = 1'b1;
    nxt.ev.ext  = 1'b1;
    add_row("mei over msi", `CSR_ADDR_MCAUSE, 0, 0, 32'h8000_0007, 1, base_v + 44,
            PRIV_MACHINE);
    nxt.ev.msip = 1'b1;
    add_row("msi masked", `CSR_ADDR_MCAUSE, 0, 0, 32'h8000_000b, 0, base_v, PRIV_MACHINE);
    add_row("mpp user again", `CSR_ADDR_MSTATUS, 1, status_word(0, 0, 2'b00),
            status_word(0, 1, 2'b11), 0, base_v, PRIV_MACHINE);
    nxt.ev.mret = 1'b1;
    add_row("mret to user", `CSR_ADDR_MSTATUS, 0, 0, 0, 0, base_v, PRIV_MACHINE);
    nxt.ev.msip = 1'b1;
    add_row("msi in user mode", `CSR_ADDR_MSTATUS, 0, 0, status_word(0, 1, 2'b00), 1,
            base_v + 12, PRIV_USER);
    // Write in a trap cycle
    nxt.ev.illegal = 1'b1;
    add_row("write during trap", `CSR_ADDR_MSCRATCH, 1, ~s_d, s_d, 1, base_v, PRIV_MACHINE);
    add_row("mscratch unchanged", `CSR_ADDR_MSCRATCH, 0, 0, s_d, 0, base_v, PRIV_MACHINE);
  endtask

  initial begin
    row_t r;
    int   waited;
    reset               = 1'b1;
    wr_en               = 1'b0;
    addr                = '0;
    wr_data             = '0;
    pc                  = '0;
    instruction         = '0;
    mtime               = 64'd0;
    mtimecmp            = 64'h0000_0003_0000_0100;
    msip                = 1'b0;
    external_interrupt  = 1'b0;
    illegal_instruction = 1'b0;
    ecall               = 1'b0;
    mret                = 1'b0;
    build_table();
    repeat (10) @(posedge clock);
    #2 reset = 1'b0;
    waited = 0;
    while (priv !== PRIV_MACHINE || trap !== 1'b0) begin
      if (waited == 20) begin
        $display("Unit did not settle in machine mode without a trap after reset");
        $display("Something failed");
        $fatal(1, "reset timeout");
      end
      @(posedge clock);
      waited++;
    end
    foreach (rows[i]) begin
      @(posedge clock);
      #2;
      r                   = rows[i];
      wr_en               = r.wr_en;
      addr                = r.addr;
      wr_data             = r.wr_data;
      pc                  = r.pc;
      instruction         = r.instruction;
      illegal_instruction = r.ev.illegal;
      ecall               = r.ev.ecall;
      mret                = r.ev.mret;
      msip                = r.ev.msip;
      external_interrupt  = r.ev.ext;
      mtime               = r.ev.timer ? mtimecmp : 64'd0;
      // Outputs are settled mid-cycle
      @(negedge clock);
      check_value({r.name, " rd_data"}, r.exp_rd, rd_data);
      check_value({r.name, " trap"}, 32'(r.exp_trap), 32'(trap));
      check_value({r.name, " trap_addr"}, r.exp_addr, trap_addr);
      check_value({r.name, " priv"}, 32'(r.exp_priv), 32'(priv));
      // mepc port shows the same register as an mepc read
      if (r.addr == `CSR_ADDR_MEPC) begin
        check_value({r.name, " mepc"}, r.exp_rd, mepc);
      end
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/csr_pkg.sv
design/csr_status.sv
design/csr_interrupts.sv
design/csr_trap_ctrl.sv
design/csr_file.sv
design/csr_unit.sv
testbench/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - include_dirs:
      - design
    files:
      - design/csr_pkg.sv
      - design/csr_status.sv
      - design/csr_interrupts.sv
      - design/csr_trap_ctrl.sv
      - design/csr_file.sv
      - design/csr_unit.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/csr_unit_tb.sv
